// ==== Makefile ====
# Verilator flow for the cube renderer

TOP := cube_render_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)
	verilator --lint-only -f filelist.f --top-module cube_render

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o sim_tb
	./obj_dir/sim_tb 2>&1 | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/cube_render_tb.sv ====
// self-checking testbench for the cube renderer
// reads passes from bench/cube_tests.txt and checks first pixels, count and checksum
`default_nettype none
`timescale 1ns/1ps

module cube_render_tb;

    localparam int MAX_RECS = 16;
    localparam int EDGES    = 12;

    logic                   clk_pix = 1'b0;
    logic                   reset;
    logic                   start;
    logic [7:0]             angle;
    geom_pkg::pixel_write_t pixel;
    logic                   pixel_we;
    logic                   busy;
    logic                   done;

    // expected values per pass
    int rec_angle [MAX_RECS];
    int rec_count [MAX_RECS];
    int rec_csum  [MAX_RECS];
    int exp_x     [MAX_RECS][EDGES];
    int exp_y     [MAX_RECS][EDGES];
    int n_recs = 0;
    bit loaded = 1'b0;

    // per pass tallies kept by the monitor
    bit          monitor_on = 1'b0;
    bit          pass_done;
    bit          prev_we;
    bit          prev_busy;
    int          cur;
    int          edge_idx;
    int          pix_cnt;
    int          done_cnt;
    logic [31:0] csum;
    logic [31:0] lfsr = 32'h7442;

    cube_render UUT (
        .clk_pix,
        .reset,
        .start,
        .angle,
        .pixel,
        .pixel_we,
        .busy,
        .done
    );

    always #10 clk_pix = ~clk_pix;

    task automatic check(input longint actual, input longint expected, input string msg);
        if (actual != expected) begin
            $display("CHECK FAILED at %0t: %s (got %0d, expected %0d)",
                     $time, msg, actual, expected);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    // next line that is neither blank nor a comment
    task automatic next_data_line(input int fd, output string s, output bit ok);
        ok = 1'b0;
        while (!ok && !$feof(fd)) begin
            s = "";
            void'($fgets(s, fd));
            if (s.len() > 1 && s[0] != "#") ok = 1'b1;
        end
    endtask

    task automatic load_tests();
        int    fd;
        string s;
        bit    ok;
        int    k;
        fd = $fopen("bench/cube_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/cube_tests.txt");
            $display("Regression failed");
            $fatal(1);
        end
        next_data_line(fd, s, ok);
        while (ok && n_recs < MAX_RECS) begin
            void'($sscanf(s, "%d %d %d", rec_angle[n_recs], rec_count[n_recs],
                          rec_csum[n_recs]));
            for (int h = 0; h < 2; h++) begin
                next_data_line(fd, s, ok);
                k = h * 6;
                void'($sscanf(s, "%d %d %d %d %d %d %d %d %d %d %d %d",
                    exp_x[n_recs][k],   exp_y[n_recs][k],   exp_x[n_recs][k+1],
                    exp_y[n_recs][k+1], exp_x[n_recs][k+2], exp_y[n_recs][k+2],
                    exp_x[n_recs][k+3], exp_y[n_recs][k+3], exp_x[n_recs][k+4],
                    exp_y[n_recs][k+4], exp_x[n_recs][k+5], exp_y[n_recs][k+5]));
            end
            n_recs++;
            next_data_line(fd, s, ok);
        end
        $fclose(fd);
    endtask

    // watch the write stream between edges where everything is stable
    always @(negedge clk_pix) begin
        if (monitor_on) begin
            if (pixel_we) begin
                check(pixel.cidx, geom_pkg::DRAW_CIDX, "colour index");
                if (!prev_we) begin
                    check(edge_idx < EDGES, 1, "more lines drawn than cube edges");
                    check(pixel.x, exp_x[cur][edge_idx],
                          $sformatf("edge %0d first x", edge_idx));
                    check(pixel.y, exp_y[cur][edge_idx],
                          $sformatf("edge %0d first y", edge_idx));
                    edge_idx++;
                end
                pix_cnt++;
                csum = csum + 32'(int'(pixel.x)) + 32'(3 * int'(pixel.y));
            end
            if (done) begin
                done_cnt++;
                check(busy, 0, "busy still high with done");
                check(prev_busy, 1, "busy low before done");
                pass_done = 1'b1;
            end
            prev_we   = pixel_we;
            prev_busy = busy;
        end
    end

    initial begin
        wait (loaded);
        #(longint'(n_recs) * 4000 * 20);
        $display("timeout: the render passes did not finish in time");
        $display("Regression failed");
        $fatal(1);
    end

    initial begin
        int gap;
        int stray_at;
        int cyc;
        reset = 1'b1;
        start = 1'b0;
        angle = '0;
        load_tests();
        loaded = 1'b1;
        repeat (2) @(posedge clk_pix);
        reset <= 1'b0;

        // quiet outputs before any start
        repeat (10) begin
            @(negedge clk_pix);
            check(pixel_we, 0, "pixel_we before start");
            check(busy, 0, "busy before start");
            check(done, 0, "done before start");
        end

        for (int r = 0; r < n_recs; r++) begin
            take_bits(4, gap);
            repeat (gap) @(posedge clk_pix);
            cur        = r;
            edge_idx   = 0;
            pix_cnt    = 0;
            done_cnt   = 0;
            csum       = '0;
            prev_we    = 1'b0;
            prev_busy  = 1'b0;
            pass_done  = 1'b0;
            monitor_on = 1'b1;
            @(posedge clk_pix);
            start <= 1'b1;
            angle <= 8'(rec_angle[r]);
            take_bits(8, stray_at);
            stray_at = stray_at + 20;  // well inside the pass
            cyc = 0;
            while (!pass_done) begin
                @(posedge clk_pix);
                cyc++;
                if (cyc == stray_at) begin
                    start <= 1'b1;
                    angle <= 8'(rec_angle[r] + 16);
                end else begin
                    start <= 1'b0;
                end
            end
            repeat (3) @(posedge clk_pix);
            check(done_cnt, 1, "done pulses per pass");
            check(edge_idx, EDGES, "lines drawn per pass");
            check(pix_cnt, rec_count[r], "pixel count");
            check(csum, 32'(rec_csum[r]), "pixel checksum");
            monitor_on = 1'b0;
        end

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/cube_tests.txt ====
# per pass: angle  pixel_count  checksum (sum of x + 3*y, mod 2^32)
# then first pixel x y of edges 0-5 on one line and edges 6-11 on the next

# zero angle, square faces, joining edges are single points
0 652 417280
0 240 80 240 80 160 0 160 0 240 80 240
80 160 0 160 0 240 80 240 80 160 0 160

# 45 degrees, diagonal faces
32 460 253920
0 240 56 184 0 128 -56 184 0 240 56 184
0 128 -56 184 0 240 56 184 0 128 -56 184

# 90 degrees
64 652 365120
0 240 0 160 -80 160 -80 240 0 240 0 160
-80 160 -80 240 0 240 0 160 -80 160 -80 240

# 180 degrees
128 652 521600
0 240 -80 240 -80 320 0 320 0 240 -80 240
-80 320 0 320 0 240 -80 240 -80 320 0 320

// ==== filelist.f ====
source/geom_pkg.sv
source/model_pkg.sv
source/model_rom.sv
source/sine_table.sv
source/edge_rotator.sv
source/draw_line.sv
source/cube_render.sv
bench/cube_render_tb.sv

// ==== source/cube_render.sv ====
// wireframe cube renderer: start a pass with an angle, pixel writes stream out
// the consumer must take one write per cycle while pixel_we is high
`default_nettype none
`timescale 1ns/1ps

module cube_render (
    input  wire logic                          clk_pix,
    input  wire logic                          reset,
    input  wire logic                          start,
    input  wire logic [model_pkg::ANGLE_W-1:0] angle,
    output geom_pkg::pixel_write_t             pixel,
    output logic                               pixel_we,
    output logic                               busy,
    output logic                               done
);

    typedef enum logic [2:0] {IDLE, FETCH, SINE, COSINE, ROT_WAIT, DRAW, FINISH} state_t;
    state_t state;

    logic [model_pkg::ANGLE_W-1:0]     angle_r;    // angle for this pass
    logic [model_pkg::ANGLE_W-1:0]     sin_angle;
    logic [model_pkg::LINE_IDW-1:0]    line_id;
    model_pkg::model_edge_t            edge_data;
    logic signed [geom_pkg::CORDW-1:0] sin_val, sin_a, cos_a;
    logic                              rot_valid;
    logic                              line_valid; // rotated line ready, starts the drawer
    geom_pkg::screen_line_t            screen_line;
    logic                              line_drawing, line_done;

    // sin(a) is looked up in fetch, cos(a) = sin(quarter turn - a) in sine
    always_comb begin
        sin_angle = (state == SINE) ? model_pkg::QUARTER_TURN - angle_r : angle_r;
    end

    always_ff @(posedge clk_pix) begin
        rot_valid <= 1'b0;
        case (state)
            IDLE: if (start) begin
                angle_r <= angle;
                line_id <= '0;
                state   <= FETCH;
            end
            FETCH: state <= SINE;  // ROM and sine reads in flight
            SINE: begin
                sin_a <= sin_val;
                state <= COSINE;
            end
            COSINE: begin
                cos_a     <= sin_val;
                rot_valid <= 1'b1;
                state     <= ROT_WAIT;
            end
            ROT_WAIT: if (line_valid) state <= DRAW;
            DRAW: if (line_done) begin
                if (line_id == model_pkg::LINE_CNT - 1) begin
                    state <= FINISH;
                end else begin
                    line_id <= line_id + 1'b1;
                    state   <= FETCH;
                end
            end
            FINISH: state <= IDLE;  // done pulse
            default: state <= IDLE;
        endcase

        if (reset) begin
            state     <= IDLE;
            rot_valid <= 1'b0;
            line_id   <= '0;
        end
    end

    always_comb begin
        busy     = (state != IDLE) && (state != FINISH);
        done     = (state == FINISH);
        pixel_we = line_drawing;
    end

    model_rom model_rom_inst (
        .clk_pix,
        .line_id,
        .edge_data
    );

    sine_table sine_table_inst (
        .clk_pix,
        .angle   (sin_angle),
        .sin_val
    );

    edge_rotator edge_rotator_inst (
        .clk_pix,
        .reset,
        .in_valid  (rot_valid),
        .edge_in   (edge_data),
        .sin_a,
        .cos_a,
        .out_valid (line_valid),
        .line_out  (screen_line)
    );

    draw_line draw_line_inst (
        .clk_pix,
        .reset,
        .start     (line_valid),
        .line_in   (screen_line),
        .pixel,
        .drawing   (line_drawing),
        .line_done
    );

    // pass ends only once the last edge has finished drawing
    assert property (@(posedge clk_pix) disable iff (reset) $rose(done) |-> !line_drawing);

endmodule

`default_nettype wire

// ==== source/draw_line.sv ====
// Bresenham line drawer for all octants, one pixel per cycle from p0 to p1
// start is taken only while idle; line_done pulses after the last pixel
`default_nettype none
`timescale 1ns/1ps

module draw_line (
    input  wire logic                   clk_pix,
    input  wire logic                   reset,
    input  wire logic                   start,
    input  wire geom_pkg::screen_line_t line_in,
    output geom_pkg::pixel_write_t      pixel,
    output logic                        drawing,
    output logic                        line_done
);

    logic signed [geom_pkg::CORDW-1:0] x, y;          // current pixel
    logic signed [geom_pkg::CORDW-1:0] x_end, y_end;
    logic signed [geom_pkg::CORDW:0]   dx, dy, err;   // dy is held negative
    logic signed [geom_pkg::CORDW:0]   dx_raw, dy_raw, dx_in, dy_in;
    logic signed [geom_pkg::CORDW+1:0] e2;
    logic signed [geom_pkg::CORDW:0]   span, step_cnt;
    logic                              right, down;
    logic                              step_x, step_y, at_end;

    function automatic logic signed [geom_pkg::CORDW:0] sext(
        input logic signed [geom_pkg::CORDW-1:0] v
    );
        return {v[geom_pkg::CORDW-1], v};
    endfunction

    always_comb begin
        dx_raw = sext(line_in.p1.x) - sext(line_in.p0.x);
        dy_raw = sext(line_in.p1.y) - sext(line_in.p0.y);
        dx_in  = dx_raw[geom_pkg::CORDW] ? -dx_raw : dx_raw;  // |x1 - x0|
        dy_in  = dy_raw[geom_pkg::CORDW] ? dy_raw : -dy_raw;  // -|y1 - y0|

        e2     = $signed({err, 1'b0});
        step_x = (e2 >= dy);
        step_y = (e2 <= dx);
        at_end = (x == x_end) && (y == y_end);
    end

    always_ff @(posedge clk_pix) begin
        line_done <= 1'b0;
        if (start && !drawing) begin
            x        <= line_in.p0.x;
            y        <= line_in.p0.y;
            x_end    <= line_in.p1.x;
            y_end    <= line_in.p1.y;
            dx       <= dx_in;
            dy       <= dy_in;
            err      <= dx_in + dy_in;
            right    <= !dx_raw[geom_pkg::CORDW];
            down     <= !dy_raw[geom_pkg::CORDW];
            span     <= (dx_in > -dy_in) ? dx_in : -dy_in;  // steps along the major axis
            step_cnt <= '0;
            drawing  <= 1'b1;
        end else if (drawing) begin
            if (at_end) begin
                drawing   <= 1'b0;
                line_done <= 1'b1;
            end else begin
                step_cnt <= step_cnt + 1'b1;
                err      <= err + (step_x ? dy : '0) + (step_y ? dx : '0);
                if (step_x) x <= right ? x + 1'b1 : x - 1'b1;
                if (step_y) y <= down ? y + 1'b1 : y - 1'b1;
            end
        end

        if (reset) begin
            drawing   <= 1'b0;
            line_done <= 1'b0;
        end
    end

    always_comb begin
        pixel.x    = x;
        pixel.y    = y;
        pixel.cidx = geom_pkg::DRAW_CIDX;
    end

    // a line never takes more than max(dx, dy) + 1 pixels
    assert property (@(posedge clk_pix) disable iff (reset) drawing |-> step_cnt <= span);

endmodule

`default_nettype wire

// ==== source/edge_rotator.sv ====
// rotates one model edge about the z axis and projects it to screen space
// three stages: multiply, truncate to integer, combine and flip y
`default_nettype none
`timescale 1ns/1ps

module edge_rotator (
    input  wire logic                              clk_pix,
    input  wire logic                              reset,
    input  wire logic                              in_valid,
    input  wire model_pkg::model_edge_t            edge_in,
    input  wire logic signed [geom_pkg::CORDW-1:0] sin_a,
    input  wire logic signed [geom_pkg::CORDW-1:0] cos_a,
    output logic                                   out_valid,
    output geom_pkg::screen_line_t                 line_out
);

    model_pkg::model_point_t pt [2];

    // full products, Q8.8 times integer
    logic signed [2*geom_pkg::CORDW-1:0] xc_w [2];
    logic signed [2*geom_pkg::CORDW-1:0] ys_w [2];
    logic signed [2*geom_pkg::CORDW-1:0] xs_w [2];
    logic signed [2*geom_pkg::CORDW-1:0] yc_w [2];

    // integer parts
    logic signed [geom_pkg::CORDW-1:0] xc [2];
    logic signed [geom_pkg::CORDW-1:0] ys [2];
    logic signed [geom_pkg::CORDW-1:0] xs [2];
    logic signed [geom_pkg::CORDW-1:0] yc [2];

    logic valid_mul;
    logic valid_trunc;

    function automatic logic signed [geom_pkg::CORDW-1:0] widen(
        input logic [model_pkg::MODEL_CORDW-1:0] c
    );
        return {{(geom_pkg::CORDW - model_pkg::MODEL_CORDW){1'b0}}, c};
    endfunction

    // drop the fraction bits, rounding toward minus infinity
    function automatic logic signed [geom_pkg::CORDW-1:0] to_int(
        input logic signed [2*geom_pkg::CORDW-1:0] p
    );
        return p[geom_pkg::CORDW+geom_pkg::FRAC_BITS-1 -: geom_pkg::CORDW];
    endfunction

    always_comb begin
        pt[0] = edge_in.p0;
        pt[1] = edge_in.p1;
    end

    always_ff @(posedge clk_pix) begin
        for (int i = 0; i < 2; i++) begin
            xc_w[i] <= widen(pt[i].x) * cos_a;
            ys_w[i] <= widen(pt[i].y) * sin_a;
            xs_w[i] <= widen(pt[i].x) * sin_a;
            yc_w[i] <= widen(pt[i].y) * cos_a;
        end

        for (int i = 0; i < 2; i++) begin
            xc[i] <= to_int(xc_w[i]);
            ys[i] <= to_int(ys_w[i]);
            xs[i] <= to_int(xs_w[i]);
            yc[i] <= to_int(yc_w[i]);
        end

        // model y points up, screen y points down
        line_out.p0.x <= xc[0] - ys[0];
        line_out.p0.y <= geom_pkg::FB_HEIGHT - (xs[0] + yc[0]);
        line_out.p1.x <= xc[1] - ys[1];
        line_out.p1.y <= geom_pkg::FB_HEIGHT - (xs[1] + yc[1]);
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            valid_mul   <= 1'b0;
            valid_trunc <= 1'b0;
            out_valid   <= 1'b0;
        end else begin
            valid_mul   <= in_valid;
            valid_trunc <= valid_mul;
            out_valid   <= valid_trunc;
        end
    end

    // every accepted edge leaves the pipe three cycles on
    assert property (@(posedge clk_pix) disable iff (reset) in_valid |-> ##3 out_valid);

endmodule

`default_nettype wire

// ==== source/geom_pkg.sv ====
// screen-space types and constants shared by the rotator, line drawer and top level
// coordinates are signed, so rotated edges may leave the framebuffer
`default_nettype none

package geom_pkg;

    localparam int CORDW     = 16;  // signed screen coordinate width
    localparam int FRAC_BITS = 8;   // Q8.8 fixed point
    localparam int CIDXW     = 4;   // colour index width

    // framebuffer size, typed to match screen coordinates
    localparam logic signed [CORDW-1:0] FB_WIDTH  = CORDW'(320);
    localparam logic signed [CORDW-1:0] FB_HEIGHT = CORDW'(240);

    localparam logic [CIDXW-1:0] DRAW_CIDX = CIDXW'(9);  // orange in the 16 colour palette

    typedef struct packed {
        logic signed [CORDW-1:0] x;
        logic signed [CORDW-1:0] y;
    } screen_point_t;

    typedef struct packed {
        screen_point_t p0;  // start of line
        screen_point_t p1;  // end of line
    } screen_line_t;

    // one framebuffer write
    typedef struct packed {
        logic signed [CORDW-1:0] x;
        logic signed [CORDW-1:0] y;
        logic [CIDXW-1:0]        cidx;
    } pixel_write_t;

endpackage

`default_nettype wire

// ==== source/model_pkg.sv ====
// model-space definitions: edge count, model coordinates and sine table sizes
`default_nettype none

package model_pkg;

    localparam int LINE_CNT    = 12;  // cube edges
    localparam int LINE_IDW    = 4;   // edge index width
    localparam int MODEL_CORDW = 8;   // unsigned model coordinate

    // sine table
    localparam int SIN_DEPTH = 64;  // entries over 0 to 90 degrees
    localparam int SIN_WIDTH = 8;   // Q0.8 samples
    localparam int ANGLE_W   = 8;   // 256 steps per turn

    localparam logic [ANGLE_W-1:0] QUARTER_TURN = ANGLE_W'(SIN_DEPTH);

    typedef struct packed {
        logic [MODEL_CORDW-1:0] x;
        logic [MODEL_CORDW-1:0] y;
        logic [MODEL_CORDW-1:0] z;
    } model_point_t;

    // one edge, 48 bits
    typedef struct packed {
        model_point_t p0;
        model_point_t p1;
    } model_edge_t;

endpackage

`default_nettype wire

// ==== source/model_rom.sv ====
// cube model ROM, one edge per address, registered output
// corners sit at 0 and 80 on each axis
`default_nettype none
`timescale 1ns/1ps

module model_rom (
    input  wire logic                           clk_pix,
    input  wire logic [model_pkg::LINE_IDW-1:0] line_id,
    output model_pkg::model_edge_t              edge_data
);

    // each entry is {x0, y0, z0, x1, y1, z1}
    always_ff @(posedge clk_pix) begin
        case (line_id)
            // near face, z = 0
            4'd0:    edge_data <= {8'd0,  8'd0,  8'd0,  8'd80, 8'd0,  8'd0};
            4'd1:    edge_data <= {8'd80, 8'd0,  8'd0,  8'd80, 8'd80, 8'd0};
            4'd2:    edge_data <= {8'd80, 8'd80, 8'd0,  8'd0,  8'd80, 8'd0};
            4'd3:    edge_data <= {8'd0,  8'd80, 8'd0,  8'd0,  8'd0,  8'd0};
            // far face, z = 80
            4'd4:    edge_data <= {8'd0,  8'd0,  8'd80, 8'd80, 8'd0,  8'd80};
            4'd5:    edge_data <= {8'd80, 8'd0,  8'd80, 8'd80, 8'd80, 8'd80};
            4'd6:    edge_data <= {8'd80, 8'd80, 8'd80, 8'd0,  8'd80, 8'd80};
            4'd7:    edge_data <= {8'd0,  8'd80, 8'd80, 8'd0,  8'd0,  8'd80};
            // edges joining the faces
            4'd8:    edge_data <= {8'd0,  8'd0,  8'd0,  8'd0,  8'd0,  8'd80};
            4'd9:    edge_data <= {8'd80, 8'd0,  8'd0,  8'd80, 8'd0,  8'd80};
            4'd10:   edge_data <= {8'd80, 8'd80, 8'd0,  8'd80, 8'd80, 8'd80};
            4'd11:   edge_data <= {8'd0,  8'd80, 8'd0,  8'd0,  8'd80, 8'd80};
            default: edge_data <= '0;  // unused addresses
        endcase
    end

endmodule

`default_nettype wire

// ==== source/sine_table.sv ====
// signed sine over a full turn from a quarter-wave table, one cycle latency
// result is Q8.8, so the peaks read as +/-256
`default_nettype none
`timescale 1ns/1ps

module sine_table (
    input  wire logic                                clk_pix,
    input  wire logic [model_pkg::ANGLE_W-1:0]       angle,
    output logic signed [geom_pkg::CORDW-1:0]        sin_val
);

    logic [1:0]                                  quadrant;
    logic [$clog2(model_pkg::SIN_DEPTH)-1:0]     idx;
    logic [$clog2(model_pkg::SIN_DEPTH)-1:0]     rom_idx;
    logic [model_pkg::SIN_WIDTH-1:0]             sample;
    logic [model_pkg::SIN_WIDTH:0]               mag;
    logic signed [geom_pkg::CORDW-1:0]           mag_s;
    logic                                        peak;

    always_comb begin
        quadrant = angle[model_pkg::ANGLE_W-1 -: 2];
        idx      = angle[$clog2(model_pkg::SIN_DEPTH)-1:0];
        // second and fourth quadrants run the table backwards, 64 - idx
        rom_idx  = quadrant[0] ? ~idx + 1'b1 : idx;
        peak     = quadrant[0] && (idx == '0);  // 90 and 270 degrees, off the table end
    end

    // sin(i * 90 / 64 degrees) * 256, top entries held at 255
    always_comb begin
        case (rom_idx)
            6'd0:  sample = 8'd0;
            6'd1:  sample = 8'd6;
            6'd2:  sample = 8'd13;
            6'd3:  sample = 8'd19;
            6'd4:  sample = 8'd25;
            6'd5:  sample = 8'd31;
            6'd6:  sample = 8'd38;
            6'd7:  sample = 8'd44;
            6'd8:  sample = 8'd50;
            6'd9:  sample = 8'd56;
            6'd10: sample = 8'd62;
            6'd11: sample = 8'd68;
            6'd12: sample = 8'd74;
            6'd13: sample = 8'd80;
            6'd14: sample = 8'd86;
            6'd15: sample = 8'd92;
            6'd16: sample = 8'd98;
            6'd17: sample = 8'd104;
            6'd18: sample = 8'd109;
            6'd19: sample = 8'd115;
            6'd20: sample = 8'd121;
            6'd21: sample = 8'd126;
            6'd22: sample = 8'd132;
            6'd23: sample = 8'd137;
            6'd24: sample = 8'd142;
            6'd25: sample = 8'd147;
            6'd26: sample = 8'd152;
            6'd27: sample = 8'd157;
            6'd28: sample = 8'd162;
            6'd29: sample = 8'd167;
            6'd30: sample = 8'd172;
            6'd31: sample = 8'd177;
            6'd32: sample = 8'd181;
            6'd33: sample = 8'd185;
            6'd34: sample = 8'd190;
            6'd35: sample = 8'd194;
            6'd36: sample = 8'd198;
            6'd37: sample = 8'd202;
            6'd38: sample = 8'd206;
            6'd39: sample = 8'd209;
            6'd40: sample = 8'd213;
            6'd41: sample = 8'd216;
            6'd42: sample = 8'd220;
            6'd43: sample = 8'd223;
            6'd44: sample = 8'd226;
            6'd45: sample = 8'd229;
            6'd46: sample = 8'd231;
            6'd47: sample = 8'd234;
            6'd48: sample = 8'd237;
            6'd49: sample = 8'd239;
            6'd50: sample = 8'd241;
            6'd51: sample = 8'd243;
            6'd52: sample = 8'd245;
            6'd53: sample = 8'd247;
            6'd54: sample = 8'd248;
            6'd55: sample = 8'd250;
            6'd56: sample = 8'd251;
            6'd57: sample = 8'd252;
            6'd58: sample = 8'd253;
            6'd59: sample = 8'd254;
            6'd60: sample = 8'd255;
            6'd61: sample = 8'd255;
            6'd62: sample = 8'd255;
            default: sample = 8'd255;
        endcase
    end

    always_comb begin
        mag   = peak ? {1'b1, {model_pkg::SIN_WIDTH{1'b0}}} : {1'b0, sample};
        mag_s = {{(geom_pkg::CORDW - model_pkg::SIN_WIDTH - 1){1'b0}}, mag};
    end

    always_ff @(posedge clk_pix) begin
        sin_val <= quadrant[1] ? -mag_s : mag_s;  // lower half of the turn is negative
    end

endmodule

`default_nettype wire
